//--- common/dcachePkg.sv
package dcachePkg;

  // cache geometry
  localparam int AddrWidth    = 32;
  localparam int WordWidth    = 64;
  localparam int LineWidth    = 256;
  localparam int BeatsPerLine = 4;
  localparam int SetCount     = 64;
  localparam int IndexWidth   = 6;
  localparam int OffsetWidth  = 5;
  localparam int TagWidth     = 21;
  // one word per refill beat, so this also sizes the beat counter
  localparam int WordSelWidth = 2;

  typedef struct packed {
    logic [TagWidth-1:0]    tag;
    logic [IndexWidth-1:0]  index;
    logic [OffsetWidth-1:0] offset;
  } addrFieldsT;

  // raw view for the memory ports, field view for the arrays
  typedef union packed {
    logic [AddrWidth-1:0] raw;
    addrFieldsT           field;
  } cacheAddrT;

  typedef struct packed {
    logic                   valid;
    logic                   write;
    cacheAddrT              addr;
    logic [WordWidth-1:0]   wdata;
    logic [WordWidth/8-1:0] wmask;
  } cpuReqT;

  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
  } memRdReqT;

  typedef struct packed {
    logic                 ready;
    logic                 beatValid;
    logic                 beatLast;
    logic [WordWidth-1:0] beat;
  } memRdRspT;

  typedef struct packed {
    logic                 valid;
    logic [AddrWidth-1:0] addr;
    logic [LineWidth-1:0] line;
  } memWrReqT;

  typedef enum logic [2:0] {
    Idle,
    Compare,
    WriteBack,
    MissReq,
    Refill,
    Replace
  } ctrlStateT;

endpackage

//--- logic/refillUnit.sv
`timescale 1ns/100ps

module refillUnit (
  input  logic                              clk,
  input  logic                              rst_n,
  input  dcachePkg::ctrlStateT              state_i,
  input  dcachePkg::cacheAddrT              lineAddr_i,
  input  logic [dcachePkg::TagWidth-1:0]    victimTag_i,
  input  logic [dcachePkg::LineWidth-1:0]   victimLine_i,
  input  dcachePkg::memRdRspT               memRdRsp_i,
  output dcachePkg::memRdReqT               memRd_o,
  output dcachePkg::memWrReqT               memWr_o,
  output logic                              refillDone_o,
  output logic [dcachePkg::LineWidth-1:0]   refillLine_o
);

  dcachePkg::cacheAddrT               rdAddr;
  dcachePkg::cacheAddrT               wbAddr;
  logic [dcachePkg::WordSelWidth-1:0] beatCnt;
  logic [dcachePkg::LineWidth-1:0]    lineBuf;
  logic                               beatEn;

  // line aligned addresses, write-back goes to the victim's own line
  always_comb begin
    rdAddr              = lineAddr_i;
    rdAddr.field.offset = '0;
    wbAddr              = lineAddr_i;
    wbAddr.field.tag    = victimTag_i;
    wbAddr.field.offset = '0;
  end

  assign memRd_o.valid = state_i == dcachePkg::MissReq;
  assign memRd_o.addr  = rdAddr.raw;
  assign memWr_o.valid = state_i == dcachePkg::WriteBack;
  assign memWr_o.addr  = wbAddr.raw;
  assign memWr_o.line  = victimLine_i;

  assign beatEn = (state_i == dcachePkg::Refill) && memRdRsp_i.beatValid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      beatCnt <= '0;
    end else if (state_i != dcachePkg::Refill) begin
      beatCnt <= '0;
    end else if (beatEn) begin
      beatCnt <= beatCnt + 1'b1;
    end
  end

  // lowest word arrives first
  always_ff @(posedge clk) begin
    if (beatEn) begin
      lineBuf[beatCnt*dcachePkg::WordWidth +: dcachePkg::WordWidth] <= memRdRsp_i.beat;
    end
  end

  assign refillDone_o = beatEn && memRdRsp_i.beatLast;
  assign refillLine_o = lineBuf;

endmodule

//--- dcache/tagStore.sv
`timescale 1ns/100ps

module tagStore (
  input  logic                           clk,
  input  logic                           rst_n,
  input  dcachePkg::cacheAddrT           addr_i,
  input  dcachePkg::ctrlStateT           state_i,
  input  logic                           storeHit_i,
  input  logic                           victimWay_i,
  output logic [1:0]                     wayHit_o,
  output logic                           victimDirty_o,
  output logic [dcachePkg::TagWidth-1:0] victimTag_o
);

  logic [dcachePkg::TagWidth-1:0]      tagArr [2][dcachePkg::SetCount];
  logic [1:0][dcachePkg::SetCount-1:0] validArr;
  logic [1:0][dcachePkg::SetCount-1:0] dirtyArr;
  logic [dcachePkg::IndexWidth-1:0]    index;
  logic                                replaceEn;
  logic                                storeEn;

  assign index     = addr_i.field.index;
  assign replaceEn = state_i == dcachePkg::Replace;
  assign storeEn   = storeHit_i && (state_i == dcachePkg::Compare);

  always_comb begin
    for (int w = 0; w < 2; w++) begin
      wayHit_o[w] = validArr[w][index] && (tagArr[w][index] == addr_i.field.tag);
    end
  end

  assign victimDirty_o = validArr[victimWay_i][index] && dirtyArr[victimWay_i][index];
  assign victimTag_o   = tagArr[victimWay_i][index];

  always_ff @(posedge clk) begin
    if (replaceEn) begin
      tagArr[victimWay_i][index] <= addr_i.field.tag;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      validArr <= '0;
    end else if (replaceEn) begin
      validArr[victimWay_i][index] <= 1'b1;
    end
  end

  // a fresh line is clean; store hits mark it dirty
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dirtyArr <= '0;
    end else if (replaceEn) begin
      dirtyArr[victimWay_i][index] <= 1'b0;
    end else if (storeEn) begin
      for (int w = 0; w < 2; w++) begin
        if (wayHit_o[w]) begin
          dirtyArr[w][index] <= 1'b1;
        end
      end
    end
  end

endmodule

//--- dcache/dataStore.sv
`timescale 1ns/100ps

module dataStore (
  input  logic                                 clk,
  input  logic [dcachePkg::IndexWidth-1:0]     index_i,
  input  logic [dcachePkg::WordSelWidth-1:0]   wordSel_i,
  input  logic [1:0]                           wayWrEn_i,
  input  logic [dcachePkg::LineWidth-1:0]      wrLine_i,
  input  logic [dcachePkg::LineWidth/8-1:0]    wrMask_i,
  input  logic                                 refilling_i,
  input  logic [1:0]                           wayHit_i,
  input  logic                                 victimWay_i,
  output logic [dcachePkg::WordWidth-1:0]      rdData_o,
  output logic [dcachePkg::LineWidth-1:0]      victimLine_o
);

  logic [dcachePkg::LineWidth-1:0]   lineArr [2][dcachePkg::SetCount];
  logic [dcachePkg::LineWidth/8-1:0] byteEn;
  logic [dcachePkg::LineWidth-1:0]   hitLine;

  // refill replaces the whole line
  assign byteEn = refilling_i ? '1 : wrMask_i;

  always_ff @(posedge clk) begin
    for (int w = 0; w < 2; w++) begin
      if (wayWrEn_i[w]) begin
        for (int b = 0; b < dcachePkg::LineWidth / 8; b++) begin
          if (byteEn[b]) begin
            lineArr[w][index_i][b*8 +: 8] <= wrLine_i[b*8 +: 8];
          end
        end
      end
    end
  end

  assign hitLine      = wayHit_i[1] ? lineArr[1][index_i] : lineArr[0][index_i];
  assign rdData_o     = hitLine[wordSel_i*dcachePkg::WordWidth +: dcachePkg::WordWidth];
  assign victimLine_o = lineArr[victimWay_i][index_i];

endmodule

//--- dcache/dcacheCtrl.sv
`timescale 1ns/100ps

module dcacheCtrl (
  input  logic                 clk,
  input  logic                 rst_n,
  input  dcachePkg::cpuReqT    cpuReq_i,
  output logic                 addrOk_o,
  output logic                 dataOk_o,
  input  logic [1:0]           wayHit_i,
  input  logic                 victimDirty_i,
  input  logic                 refillDone_i,
  input  logic                 memRdAccept_i,
  input  logic                 memWrReady_i,
  output dcachePkg::ctrlStateT state_o,
  output dcachePkg::cpuReqT    reqLatch_o,
  output logic                 victimWay_o,
  output logic [1:0]           wayWrEn_o
);

  dcachePkg::ctrlStateT curState;
  dcachePkg::ctrlStateT nextState;
  logic                 cacheHit;
  logic                 inCompare;
  logic                 accept;
  logic                 victimToggle;
  logic                 victimLatch;

  assign inCompare = curState == dcachePkg::Compare;
  assign cacheHit  = |wayHit_i;

  // new requests only when idle or when the current one hits
  assign addrOk_o = (curState == dcachePkg::Idle) || (inCompare && cacheHit);
  assign dataOk_o = inCompare && cacheHit;
  assign accept   = cpuReq_i.valid && addrOk_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      curState <= dcachePkg::Idle;
    end else begin
      curState <= nextState;
    end
  end

  always_comb begin
    nextState = curState;
    case (curState)
      dcachePkg::Idle: begin
        if (accept) begin
          nextState = dcachePkg::Compare;
        end
      end
      dcachePkg::Compare: begin
        if (cacheHit) begin
          nextState = accept ? dcachePkg::Compare : dcachePkg::Idle;
        end else if (victimDirty_i) begin
          nextState = dcachePkg::WriteBack;
        end else begin
          nextState = dcachePkg::MissReq;
        end
      end
      dcachePkg::WriteBack: begin
        if (memWrReady_i) begin
          nextState = dcachePkg::MissReq;
        end
      end
      dcachePkg::MissReq: begin
        if (memRdAccept_i) begin
          nextState = dcachePkg::Refill;
        end
      end
      dcachePkg::Refill: begin
        if (refillDone_i) begin
          nextState = dcachePkg::Replace;
        end
      end
      // line is in place, so the retried compare hits
      dcachePkg::Replace: begin
        nextState = dcachePkg::Compare;
      end
      default: begin
        nextState = dcachePkg::Idle;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      reqLatch_o <= '0;
    end else if (accept) begin
      reqLatch_o <= cpuReq_i;
    end
  end

  // round robin victim, frozen for the rest of the miss
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      victimToggle <= 1'b0;
      victimLatch  <= 1'b0;
    end else if (inCompare && !cacheHit) begin
      victimToggle <= ~victimToggle;
      victimLatch  <= victimToggle;
    end
  end

  assign victimWay_o = inCompare ? victimToggle : victimLatch;

  always_comb begin
    wayWrEn_o = 2'b00;
    if (curState == dcachePkg::Replace) begin
      wayWrEn_o[victimLatch] = 1'b1;
    end else if (inCompare && cacheHit && reqLatch_o.write) begin
      wayWrEn_o = wayHit_i;
    end
  end

  assign state_o = curState;

endmodule

//--- dcache/dcacheTop.sv
`timescale 1ns/100ps

module dcacheTop (
  input  logic                              clk,
  input  logic                              rst_n,
  input  dcachePkg::cpuReqT                 cpuReq_i,
  output logic                              addrOk_o,
  output logic                              dataOk_o,
  output logic [dcachePkg::WordWidth-1:0]   rdData_o,
  output dcachePkg::memRdReqT               memRd_o,
  input  dcachePkg::memRdRspT               memRdRsp_i,
  output dcachePkg::memWrReqT               memWr_o,
  input  logic                              memWrReady_i
);

  dcachePkg::ctrlStateT                    ctrlState;
  dcachePkg::cpuReqT                       reqLatch;
  logic                                    victimWay;
  logic [1:0]                              wayWrEn;
  logic [1:0]                              wayHit;
  logic                                    victimDirty;
  logic [dcachePkg::TagWidth-1:0]          victimTag;
  logic [dcachePkg::LineWidth-1:0]         victimLine;
  logic                                    refillDone;
  logic [dcachePkg::LineWidth-1:0]         refillLine;
  logic [dcachePkg::WordSelWidth-1:0]      wordSel;
  logic [dcachePkg::LineWidth-1:0]         storeLine;
  logic [dcachePkg::LineWidth/8-1:0]       storeMask;
  logic [dcachePkg::LineWidth-1:0]         wrLine;
  logic                                    refilling;
  logic                                    storeHit;
  logic                                    memRdAccept;

  assign memRdAccept = memRd_o.valid && memRdRsp_i.ready;
  assign refilling   = ctrlState == dcachePkg::Replace;
  assign storeHit    = |wayWrEn;

  // store word lands in the byte lanes of its own word slot
  assign wordSel   = reqLatch.addr.field.offset[dcachePkg::OffsetWidth-1 -: dcachePkg::WordSelWidth];
  assign storeLine = {dcachePkg::BeatsPerLine{reqLatch.wdata}};
  assign storeMask = (dcachePkg::LineWidth/8)'(reqLatch.wmask) << {wordSel, 3'b000};
  assign wrLine    = refilling ? refillLine : storeLine;

  dcacheCtrl uCtrl (
    .clk           (clk),
    .rst_n         (rst_n),
    .cpuReq_i      (cpuReq_i),
    .addrOk_o      (addrOk_o),
    .dataOk_o      (dataOk_o),
    .wayHit_i      (wayHit),
    .victimDirty_i (victimDirty),
    .refillDone_i  (refillDone),
    .memRdAccept_i (memRdAccept),
    .memWrReady_i  (memWrReady_i),
    .state_o       (ctrlState),
    .reqLatch_o    (reqLatch),
    .victimWay_o   (victimWay),
    .wayWrEn_o     (wayWrEn)
  );

  tagStore uTags (
    .clk           (clk),
    .rst_n         (rst_n),
    .addr_i        (reqLatch.addr),
    .state_i       (ctrlState),
    .storeHit_i    (storeHit),
    .victimWay_i   (victimWay),
    .wayHit_o      (wayHit),
    .victimDirty_o (victimDirty),
    .victimTag_o   (victimTag)
  );

  dataStore uData (
    .clk          (clk),
    .index_i      (reqLatch.addr.field.index),
    .wordSel_i    (wordSel),
    .wayWrEn_i    (wayWrEn),
    .wrLine_i     (wrLine),
    .wrMask_i     (storeMask),
    .refilling_i  (refilling),
    .wayHit_i     (wayHit),
    .victimWay_i  (victimWay),
    .rdData_o     (rdData_o),
    .victimLine_o (victimLine)
  );

  refillUnit uRefill (
    .clk          (clk),
    .rst_n        (rst_n),
    .state_i      (ctrlState),
    .lineAddr_i   (reqLatch.addr),
    .victimTag_i  (victimTag),
    .victimLine_i (victimLine),
    .memRdRsp_i   (memRdRsp_i),
    .memRd_o      (memRd_o),
    .memWr_o      (memWr_o),
    .refillDone_o (refillDone),
    .refillLine_o (refillLine)
  );

endmodule

//--- tb/dcacheCtrl_asserts.sv
`timescale 1ns/100ps

module dcacheCtrl_asserts (
  input logic                 clk,
  input logic                 rst_n,
  input dcachePkg::ctrlStateT state_i,
  input logic                 dataOk_i,
  input logic                 victimDirty_i,
  input logic                 memRdAccept_i,
  input logic                 memWrReady_i,
  input logic [1:0]           wayHit_i
);

  int failCount = 0;

  // the dirty victim stays selected until the memory takes the line
  assert property (@(posedge clk) disable iff (!rst_n)
    (state_i == dcachePkg::WriteBack && !memWrReady_i)
      |=> (state_i == dcachePkg::WriteBack && victimDirty_i))
    else begin
      failCount++;
      $error("write-back request dropped before memWrReady_i");
    end

  // no response while a memory handshake is in progress
  assert property (@(posedge clk) disable iff (!rst_n)
    dataOk_i |-> (!memRdAccept_i && !memWrReady_i))
    else begin
      failCount++;
      $error("dataOk_o raised while a memory request is active");
    end

  // a line lives in one way only
  assert property (@(posedge clk) disable iff (!rst_n) !(&wayHit_i))
    else begin
      failCount++;
      $error("both ways hit at once");
    end

endmodule

bind dcacheCtrl dcacheCtrl_asserts uAsserts (
  .clk           (clk),
  .rst_n         (rst_n),
  .state_i       (state_o),
  .dataOk_i      (dataOk_o),
  .victimDirty_i (victimDirty_i),
  .memRdAccept_i (memRdAccept_i),
  .memWrReady_i  (memWrReady_i),
  .wayHit_i      (wayHit_i)
);

//--- tb/dcacheChecker.sv
`timescale 1ns/100ps

module dcacheChecker (
  input  logic                clk,
  input  logic                rst_n,
  input  dcachePkg::cpuReqT   cpuReq_i,
  input  logic                addrOk_i,
  input  logic                dataOk_i,
  input  logic [63:0]         rdData_i,
  input  dcachePkg::memRdReqT memRd_i,
  input  dcachePkg::memWrReqT memWr_i,
  input  logic                memWrReady_i,
  input  logic [63:0]         expData_i,
  input  logic                expCheck_i,
  input  logic                expHit_i,
  output int                  errCount_o
);

  typedef struct packed {
    dcachePkg::cpuReqT req;
    logic [63:0]       expData;
    logic              expCheck;
    logic              expHit;
    int                acceptCycle;
  } pendingT;

  pendingT     pending [$];
  logic [63:0] shadow [logic [31:0]];
  int          cycle;

  // untouched words keep the fill pattern
  function automatic logic [63:0] shadowWord(input logic [31:0] addr);
    if (shadow.exists(addr)) begin
      return shadow[addr];
    end
    return {addr, ~addr};
  endfunction

  task automatic flagValue(input string what, input logic [63:0] got, input logic [63:0] want);
    $display("[ERROR] %0t: %s got %h expected %h", $time, what, got, want);
    errCount_o++;
  endtask

  always @(posedge clk) begin
    pendingT     done;
    logic [31:0] wordAddr;
    logic [63:0] model;
    cycle++;
    if (!rst_n) begin
      if (!addrOk_i || memRd_i.valid || memWr_i.valid) begin
        $display("[ERROR] %0t: cache ports are not idle during reset", $time);
        errCount_o++;
      end
    end else begin
      // retire first, a new request may be taken on the same edge
      if (dataOk_i) begin
        if (pending.size() == 0) begin
          $display("dataOk_o came at %0t with no request pending", $time);
          errCount_o++;
        end else begin
          done     = pending.pop_front();
          wordAddr = done.req.addr.raw & ~32'h7;
          model    = shadowWord(wordAddr);
          if (done.expHit && (cycle - done.acceptCycle) != 1) begin
            $display("[ERROR] %0t: hit at %h took %0d cycles", $time, wordAddr,
                     cycle - done.acceptCycle);
            errCount_o++;
          end
          if (done.req.write) begin
            for (int b = 0; b < 8; b++) begin
              if (done.req.wmask[b]) begin
                model[b*8 +: 8] = done.req.wdata[b*8 +: 8];
              end
            end
            shadow[wordAddr] = model;
          end else begin
            if (rdData_i !== model) begin
              flagValue("load vs shadow memory", rdData_i, model);
            end
            if (done.expCheck && rdData_i !== done.expData) begin
              flagValue("load vs table", rdData_i, done.expData);
            end
          end
        end
      end
      if (cpuReq_i.valid && addrOk_i) begin
        pending.push_back('{cpuReq_i, expData_i, expCheck_i, expHit_i, cycle});
      end
      if (memWr_i.valid && memWrReady_i) begin
        for (int i = 0; i < 4; i++) begin
          model = shadowWord(memWr_i.addr + 32'(i * 8));
          if (memWr_i.line[i*64 +: 64] !== model) begin
            flagValue("write-back word", memWr_i.line[i*64 +: 64], model);
          end
        end
      end
    end
  end

endmodule

//--- tb/dcacheTb.sv
`timescale 1ns/100ps

// line memory with its own storage, random ready delays of 0 to 3 cycles
module memResponder (
  input  logic                clk,
  input  dcachePkg::memRdReqT memRd_i,
  output dcachePkg::memRdRspT memRdRsp_o,
  input  dcachePkg::memWrReqT memWr_i,
  output logic                memWrReady_o
);

  logic [63:0]         mem [logic [31:0]];
  dcachePkg::memWrReqT wrHeld;
  logic [31:0]         rdBase;
  int                  wrWait;
  int                  rdWait;
  int                  beatIdx;

  function automatic logic [63:0] fetchWord(input logic [31:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return {addr, ~addr};
  endfunction

  initial begin
    void'($urandom(48303));
    memRdRsp_o   = '0;
    memWrReady_o = 1'b0;
    wrWait       = 0;
    rdWait       = 0;
    beatIdx      = 4;
    forever begin
      @(negedge clk);
      // ready was up at the last edge, so the line was taken
      if (memWrReady_o) begin
        for (int i = 0; i < 4; i++) begin
          mem[wrHeld.addr + 32'(i * 8)] = wrHeld.line[i*64 +: 64];
        end
        memWrReady_o = 1'b0;
        wrWait       = $urandom % 4;
      end else if (memWr_i.valid) begin
        if (wrWait == 0) begin
          wrHeld       = memWr_i;
          memWrReady_o = 1'b1;
        end else begin
          wrWait--;
        end
      end
      memRdRsp_o.beatValid = 1'b0;
      memRdRsp_o.beatLast  = 1'b0;
      if (memRdRsp_o.ready) begin
        memRdRsp_o.ready = 1'b0;
        rdWait           = $urandom % 4;
        beatIdx          = 0;
      end else if (beatIdx >= 4 && memRd_i.valid) begin
        if (rdWait == 0) begin
          memRdRsp_o.ready = 1'b1;
          rdBase           = memRd_i.addr;
        end else begin
          rdWait--;
        end
      end
      // beats back to back, lowest word first
      if (beatIdx < 4) begin
        memRdRsp_o.beatValid = 1'b1;
        memRdRsp_o.beatLast  = beatIdx == 3;
        memRdRsp_o.beat      = fetchWord(rdBase + 32'(beatIdx * 8));
        beatIdx++;
      end
    end
  end

endmodule

module dcacheTb;

  localparam int EntryCount = 14;
  localparam int WaitLimit  = 200;

  typedef struct packed {
    logic        write;
    logic [31:0] addr;
    logic [63:0] wdata;
    logic [7:0]  wmask;
    logic [63:0] expData;
    logic        expHit;
  } entryT;

  // index 0 lines at tags 2, 4, 6 and 10 force evictions
  localparam entryT StimTable [EntryCount] = '{
    '{1'b0, 32'h0000_1000, 64'h0, 8'h00, 64'h0000_1000_FFFF_EFFF, 1'b0},
    '{1'b0, 32'h0000_1008, 64'h0, 8'h00, 64'h0000_1008_FFFF_EFF7, 1'b1},
    '{1'b1, 32'h0000_1008, 64'hAAAA_BBBB_CCCC_DDDD, 8'h0F, 64'h0, 1'b1},
    '{1'b0, 32'h0000_1008, 64'h0, 8'h00, 64'h0000_1008_CCCC_DDDD, 1'b1},
    '{1'b0, 32'h0000_2000, 64'h0, 8'h00, 64'h0000_2000_FFFF_DFFF, 1'b0},
    '{1'b0, 32'h0000_3000, 64'h0, 8'h00, 64'h0000_3000_FFFF_CFFF, 1'b0},
    '{1'b0, 32'h0000_1008, 64'h0, 8'h00, 64'h0000_1008_CCCC_DDDD, 1'b0},
    '{1'b0, 32'h0000_3010, 64'h0, 8'h00, 64'h0000_3010_FFFF_CFEF, 1'b1},
    '{1'b1, 32'h0000_3018, 64'h1122_3344_5566_7788, 8'hFF, 64'h0, 1'b1},
    '{1'b0, 32'h0000_3018, 64'h0, 8'h00, 64'h1122_3344_5566_7788, 1'b1},
    '{1'b0, 32'h0000_5000, 64'h0, 8'h00, 64'h0000_5000_FFFF_AFFF, 1'b0},
    '{1'b0, 32'h0000_3018, 64'h0, 8'h00, 64'h1122_3344_5566_7788, 1'b0},
    '{1'b1, 32'h0040_0020, 64'hDEAD_BEEF_0000_0000, 8'hF0, 64'h0, 1'b0},
    '{1'b0, 32'h0040_0020, 64'h0, 8'h00, 64'hDEAD_BEEF_FFBF_FFDF, 1'b1}
  };

  logic                clk = 1'b0;
  logic                rst_n;
  dcachePkg::cpuReqT   cpuReq;
  logic                addrOk;
  logic                dataOk;
  logic [63:0]         rdData;
  dcachePkg::memRdReqT memRd;
  dcachePkg::memRdRspT memRdRsp;
  dcachePkg::memWrReqT memWr;
  logic                memWrReady;
  logic [63:0]         expData;
  logic                expCheck;
  logic                expHit;
  int                  errCount;
  int                  timeoutCount;
  int                  doneCount;

  always #20 clk = ~clk;

  always @(posedge clk) begin
    if (dataOk) begin
      doneCount++;
    end
  end

  dcacheTop UUT (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpuReq_i     (cpuReq),
    .addrOk_o     (addrOk),
    .dataOk_o     (dataOk),
    .rdData_o     (rdData),
    .memRd_o      (memRd),
    .memRdRsp_i   (memRdRsp),
    .memWr_o      (memWr),
    .memWrReady_i (memWrReady)
  );

  memResponder uMem (
    .clk          (clk),
    .memRd_i      (memRd),
    .memRdRsp_o   (memRdRsp),
    .memWr_i      (memWr),
    .memWrReady_o (memWrReady)
  );

  dcacheChecker uCheck (
    .clk          (clk),
    .rst_n        (rst_n),
    .cpuReq_i     (cpuReq),
    .addrOk_i     (addrOk),
    .dataOk_i     (dataOk),
    .rdData_i     (rdData),
    .memRd_i      (memRd),
    .memWr_i      (memWr),
    .memWrReady_i (memWrReady),
    .expData_i    (expData),
    .expCheck_i   (expCheck),
    .expHit_i     (expHit),
    .errCount_o   (errCount)
  );

  // called on a falling edge, returns one falling edge after acceptance
  task automatic applyEntry(input int idx, output bit ok);
    int waitCycles;
    ok              = 1'b1;
    waitCycles      = 0;
    cpuReq.valid    = 1'b1;
    cpuReq.write    = StimTable[idx].write;
    cpuReq.addr.raw = StimTable[idx].addr;
    cpuReq.wdata    = StimTable[idx].wdata;
    cpuReq.wmask    = StimTable[idx].wmask;
    expData         = StimTable[idx].expData;
    expCheck        = !StimTable[idx].write;
    expHit          = StimTable[idx].expHit;
    while (!addrOk && ok) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles >= WaitLimit) begin
        $display("timeout: addrOk_o stayed low for %0d cycles at entry %0d", waitCycles, idx);
        timeoutCount++;
        ok = 1'b0;
      end
    end
    if (ok) begin
      @(negedge clk);
      cpuReq.valid = 1'b0;
    end
  endtask

  initial begin
    bit ok;
    bit aborted;
    int waitCycles;
    int assertFails;
    rst_n        = 1'b0;
    cpuReq       = '0;
    expData      = '0;
    expCheck     = 1'b0;
    expHit       = 1'b0;
    timeoutCount = 0;
    aborted      = 1'b0;
    repeat (5) @(negedge clk);
    rst_n = 1'b1;

    for (int i = 0; i < EntryCount && !aborted; i++) begin
      applyEntry(i, ok);
      aborted = !ok;
    end

    waitCycles = 0;
    while (!aborted && doneCount < EntryCount) begin
      @(negedge clk);
      waitCycles++;
      if (waitCycles >= WaitLimit) begin
        $display("timeout: only %0d of %0d requests completed", doneCount, EntryCount);
        timeoutCount++;
        aborted = 1'b1;
      end
    end
    // a few idle cycles catch stray dataOk_o pulses
    repeat (4) @(negedge clk);

    assertFails = UUT.uCtrl.uAsserts.failCount;
    $display("errors: %0d mismatches, %0d timeouts, %0d assertion failures",
             errCount, timeoutCount, assertFails);
    if (errCount == 0 && timeoutCount == 0 && assertFails == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
common/dcachePkg.sv
logic/refillUnit.sv
dcache/tagStore.sv
dcache/dataStore.sv
dcache/dcacheCtrl.sv
dcache/dcacheTop.sv
tb/dcacheCtrl_asserts.sv
tb/dcacheChecker.sv
tb/dcacheTb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dcacheTb -f files.f
./obj_dir/VdcacheTb | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
